// File: vlog.f
src/ghash_pkg.sv
src/gcm_msg_pkg.sv
src/gcm_block_sequencer.sv
src/ghash_block_fifo.sv
src/ghash_accumulator.sv
src/gcm_ghash_top.sv
testbench/gcm_ghash_assert.sv
testbench/tb_gcm_ghash.sv

// File: run.sh
#!/bin/sh
# Build and run the GHASH testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_gcm_ghash -f vlog.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "=== PASS ===" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: testbench/tb_gcm_ghash.sv
module tb_gcm_ghash;

    timeunit 1ns;
    timeprecision 1ps;

    import ghash_pkg::*;
    import gcm_msg_pkg::*;

    localparam int  CLK_PERIOD      = 20;
    localparam int  TAG_WAIT_CYCLES = 40 * 20;
    localparam time WATCHDOG_NS     = 6 * 40 * 20 * CLK_PERIOD;

    logic     clk;
    logic     rst_n;
    logic     start;
    msg_cfg_t cfg;
    logic     in_valid;
    logic     in_ready;
    beat_t    in_beat;
    block_t   tag;
    logic     tag_valid;
    logic     aad_done;
    logic     text_done;

    integer   seed;
    int       errors;
    int       checks;
    int       stall_cnt;

    // Current message, kept for the reference model
    beat_t    msg_aad[$];
    beat_t    msg_text[$];
    bit_len_t len_aad;
    bit_len_t len_text;

    gcm_ghash_top #(
        .DIGIT_BITS (8),
        .BUF_DEPTH  (4)
    ) gcm_ghash_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cfg       (cfg),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .tag       (tag),
        .tag_valid (tag_valid),
        .aad_done  (aad_done),
        .text_done (text_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Reference model
    // --------------------
    function automatic block_t apply_keep(input block_t data, input keep_t keep);
        block_t res;
        res = '0;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            if (keep[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // GF(2^128) product, one bit of x per step from its top bit
    function automatic block_t gf_mul(input block_t x, input block_t y);
        block_t z;
        block_t v;
        z = '0;
        v = y;
        for (int i = 0; i < BLOCK_BITS; i++) begin
            if (x[BLOCK_BITS-1-i]) begin
                z = z ^ v;
            end
            v = v[0] ? ((v >> 1) ^ GHASH_R) : (v >> 1);
        end
        return z;
    endfunction

    function automatic block_t expected_tag(input block_t h);
        block_t y;
        y = '0;
        foreach (msg_aad[i]) begin
            y = gf_mul(y ^ apply_keep(msg_aad[i].data, msg_aad[i].keep), h);
        end
        foreach (msg_text[i]) begin
            y = gf_mul(y ^ apply_keep(msg_text[i].data, msg_text[i].keep), h);
        end
        y = gf_mul(y ^ {len_aad, len_text}, h);
        return y;
    endfunction

    // --------------------
    // Stimulus helpers
    // --------------------
    function automatic block_t rand_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Valid bytes are the first ones of the block, in the top keep bits
    function automatic keep_t keep_for(input int n_bytes);
        keep_t k;
        k = 16'hFFFF << (BLOCK_BYTES - n_bytes);
        return k;
    endfunction

    function automatic bit_len_t seg_bits(input int n_blocks, input int last_bytes);
        if (n_blocks == 0) begin
            return '0;
        end
        return bit_len_t'((n_blocks - 1) * BLOCK_BITS + last_bytes * 8);
    endfunction

    task automatic build_msg(input int n_aad, input int n_text,
                             input int aad_last, input int text_last);
        beat_t b;
        msg_aad.delete();
        msg_text.delete();
        for (int i = 0; i < n_aad; i++) begin
            b.data = rand_block();
            b.last = (i == n_aad - 1);
            b.keep = b.last ? keep_for(aad_last) : '1;
            msg_aad.push_back(b);
        end
        for (int i = 0; i < n_text; i++) begin
            b.data = rand_block();
            b.last = (i == n_text - 1);
            b.keep = b.last ? keep_for(text_last) : '1;
            msg_text.push_back(b);
        end
        len_aad  = seg_bits(n_aad, aad_last);
        len_text = seg_bits(n_text, text_last);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // --------------------
    // Checks
    // --------------------
    task automatic check_block(input string name, input block_t act, input block_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %b, expected %b", $time, name, act, exp);
        end
    endtask

    // --------------------
    // DUT drivers
    // --------------------
    task automatic start_msg(input block_t h);
        cfg.len_aad_bits  = len_aad;
        cfg.len_text_bits = len_text;
        cfg.h             = h;
        start             = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    // Holds the beat until in_ready was high at the edge
    task automatic send_beat(input beat_t b);
        logic taken;
        in_valid = 1'b1;
        in_beat  = b;
        do begin
            taken = in_ready;
            if (!taken) begin
                stall_cnt++;
            end
            next_cycle();
        end while (!taken);
    endtask

    task automatic send_all();
        foreach (msg_aad[i]) begin
            send_beat(msg_aad[i]);
        end
        foreach (msg_text[i]) begin
            send_beat(msg_text[i]);
        end
        in_valid = 1'b0;
    endtask

    task automatic finish_msg(input block_t h);
        int n;
        n = 0;
        while (!tag_valid && n < TAG_WAIT_CYCLES) begin
            next_cycle();
            n++;
        end
        if (tag_valid) begin
            check_block("tag", tag, expected_tag(h));
        end else begin
            errors++;
            $display("tag_valid did not rise within %0d cycles at t=%0t",
                     TAG_WAIT_CYCLES, $time);
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_full_msg();
        block_t h;
        h = rand_block();
        build_msg(3, 4, 16, 16);
        start_msg(h);
        send_all();
        finish_msg(h);
        check_flag("aad_done", aad_done, 1'b1);
        check_flag("text_done", text_done, 1'b1);
    endtask

    task automatic test_partial_last();
        block_t h;
        h = rand_block();
        build_msg(2, 3, 5, 11);
        start_msg(h);
        send_all();
        finish_msg(h);
    endtask

    task automatic test_empty_aad();
        block_t h;
        h = rand_block();
        build_msg(0, 3, 16, 9);
        start_msg(h);
        check_flag("aad_done", aad_done, 1'b1);
        check_flag("text_done", text_done, 1'b0);
        send_all();
        finish_msg(h);
        check_flag("text_done", text_done, 1'b1);
    endtask

    task automatic test_empty_msg();
        block_t h;
        h = rand_block();
        build_msg(0, 0, 16, 16);
        start_msg(h);
        check_flag("aad_done", aad_done, 1'b1);
        check_flag("text_done", text_done, 1'b1);
        finish_msg(h);
    endtask

    task automatic test_back_pressure();
        block_t h;
        h = rand_block();
        build_msg(0, 20, 16, 16);
        stall_cnt = 0;
        start_msg(h);
        send_all();
        finish_msg(h);
        check_flag("in_ready stalled", stall_cnt > 0, 1'b1);
    endtask

    task automatic test_back_to_back();
        block_t h1;
        block_t h2;
        h1 = rand_block();
        h2 = rand_block();
        build_msg(1, 2, 16, 7);
        start_msg(h1);
        send_all();
        finish_msg(h1);
        build_msg(2, 1, 3, 16);
        start_msg(h2);
        check_flag("tag_valid", tag_valid, 1'b0);
        send_all();
        finish_msg(h2);
    endtask

    // Ends a run that stopped making progress
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        cfg      = '0;
        in_valid = 1'b0;
        in_beat  = '0;
        seed     = 32'h5857bce6;
        errors   = 0;
        checks   = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_flag("in_ready", in_ready, 1'b0);
        check_flag("tag_valid", tag_valid, 1'b0);
        check_flag("aad_done", aad_done, 1'b0);
        check_flag("text_done", text_done, 1'b0);
        next_cycle();

        test_full_msg();
        test_partial_last();
        test_empty_aad();
        test_empty_msg();
        test_back_pressure();
        test_back_to_back();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: testbench/gcm_ghash_assert.sv
module gcm_ghash_assert #(
    parameter int BUF_DEPTH = 4
) (
    input logic               clk,
    input logic               rst_n,
    input logic               start,
    input logic               in_valid,
    input logic               in_ready,
    input gcm_msg_pkg::beat_t in_beat,
    input logic               push,
    input logic               pop,
    input logic               full,
    input logic               tag_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // FIFO occupancy seen from its push and pop handshakes alone
    int occ;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ <= 0;
        end else begin
            occ <= occ + int'(push) - int'(pop);
        end
    end

    // Stalled beat stays on the bus unchanged
    beat_held: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_beat)))
        else $error("Input beat changed while stalled");

    no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (occ < BUF_DEPTH))
        else $error("FIFO push while full");

    tag_cleared: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> !tag_valid)
        else $error("tag_valid high in the cycle after start");

endmodule

bind gcm_ghash_top gcm_ghash_assert #(
    .BUF_DEPTH (BUF_DEPTH)
) u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .push      (push),
    .pop       (pop),
    .full      (full),
    .tag_valid (tag_valid)
);

// File: src/gcm_ghash_top.sv
module gcm_ghash_top #(
    parameter int DIGIT_BITS = 8,
    parameter int BUF_DEPTH  = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  gcm_msg_pkg::msg_cfg_t cfg,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  gcm_msg_pkg::beat_t    in_beat,
    output ghash_pkg::block_t     tag,
    output logic                  tag_valid,
    output logic                  aad_done,
    output logic                  text_done
);

    import gcm_msg_pkg::*;

    logic        push;
    logic        full;
    logic        pop;
    logic        pop_valid;
    ghash_item_t item;
    ghash_item_t pop_item;

    // --------------------
    // Producer
    // --------------------
    gcm_block_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cfg       (cfg),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .full      (full),
        .push      (push),
        .item      (item),
        .aad_done  (aad_done),
        .text_done (text_done)
    );

    // Decouples the stream from the multi-cycle multiply
    ghash_block_fifo #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .item      (item),
        .full      (full),
        .pop       (pop),
        .pop_valid (pop_valid),
        .pop_item  (pop_item)
    );

    // --------------------
    // Consumer
    // --------------------
    ghash_accumulator #(
        .DIGIT_BITS (DIGIT_BITS)
    ) u_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .h         (cfg.h),
        .pop_valid (pop_valid),
        .pop_item  (pop_item),
        .pop       (pop),
        .tag       (tag),
        .tag_valid (tag_valid)
    );

endmodule

// File: src/ghash_accumulator.sv
module ghash_accumulator #(
    parameter int DIGIT_BITS = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  ghash_pkg::block_t        h,
    input  logic                     pop_valid,
    input  gcm_msg_pkg::ghash_item_t pop_item,
    output logic                     pop,
    output ghash_pkg::block_t        tag,
    output logic                     tag_valid
);

    import ghash_pkg::*;

    localparam int STEPS = BLOCK_BITS / DIGIT_BITS;
    localparam int CW    = $clog2(STEPS + 1);

    typedef enum logic {
        ACC_IDLE,
        ACC_MUL
    } acc_state_e;

    acc_state_e state_q;
    logic [CW-1:0] cnt_q;
    logic       fin_q;
    logic       tag_valid_q;

    block_t     h_q;
    block_t     h_sh;
    block_t     y_q;
    block_t     z_q;
    block_t     v_q;
    block_t     z_nx;
    block_t     v_nx;
    block_t     tag_q;

    logic       start_ok;
    logic       last_step;

    assign start_ok  = start && (state_q == ACC_IDLE);
    assign pop       = (state_q == ACC_IDLE) && pop_valid && !start;
    assign last_step = (state_q == ACC_MUL) && (cnt_q == CW'(STEPS - 1));

    // --------------------
    // Digit of the multiply
    // --------------------
    // Right-shift GCM multiply, scanning H from its first (top) bit
    always_comb begin
        z_nx = z_q;
        v_nx = v_q;
        for (int j = 0; j < DIGIT_BITS; j++) begin
            if (h_sh[BLOCK_BITS-1-j]) begin
                z_nx = z_nx ^ v_nx;
            end
            if (v_nx[0]) begin
                v_nx = (v_nx >> 1) ^ GHASH_R;
            end else begin
                v_nx = v_nx >> 1;
            end
        end
    end

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ACC_IDLE;
            cnt_q       <= '0;
            fin_q       <= 1'b0;
            tag_valid_q <= 1'b0;
        end else if (start_ok) begin
            tag_valid_q <= 1'b0;
        end else if (pop) begin
            state_q <= ACC_MUL;
            cnt_q   <= '0;
            fin_q   <= pop_item.is_final;
        end else if (state_q == ACC_MUL) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_step) begin
                state_q <= ACC_IDLE;
                if (fin_q) begin
                    tag_valid_q <= 1'b1;
                end
            end
        end
    end

    // Datapath, Y absorbs the popped block before each multiply
    always_ff @(posedge clk) begin
        if (start_ok) begin
            h_q <= h;
            y_q <= '0;
        end else if (pop) begin
            v_q  <= y_q ^ pop_item.blk;
            z_q  <= '0;
            h_sh <= h_q;
        end else if (state_q == ACC_MUL) begin
            z_q  <= z_nx;
            v_q  <= v_nx;
            h_sh <= h_sh << DIGIT_BITS;
            if (last_step) begin
                y_q <= z_nx;
                if (fin_q) begin
                    tag_q <= z_nx;
                end
            end
        end
    end

    assign tag       = tag_q;
    assign tag_valid = tag_valid_q;

endmodule

// File: src/ghash_block_fifo.sv
module ghash_block_fifo #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  gcm_msg_pkg::ghash_item_t item,
    output logic                     full,
    input  logic                     pop,
    output logic                     pop_valid,
    output gcm_msg_pkg::ghash_item_t pop_item
);

    import gcm_msg_pkg::*;

    localparam int AW = $clog2(BUF_DEPTH);

    ghash_item_t   mem [BUF_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    logic          wr_en;
    logic          rd_en;

    assign full      = (count == (AW+1)'(BUF_DEPTH));
    assign pop_valid = (count != '0);
    assign pop_item  = mem[rd_ptr];

    assign wr_en = push && !full;
    assign rd_en = pop && pop_valid;

    // --------------------
    // Pointers and occupancy
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count unchanged
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= item;
        end
    end

endmodule

// File: src/gcm_block_sequencer.sv
module gcm_block_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  gcm_msg_pkg::msg_cfg_t    cfg,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  gcm_msg_pkg::beat_t       in_beat,
    input  logic                     full,
    output logic                     push,
    output gcm_msg_pkg::ghash_item_t item,
    output logic                     aad_done,
    output logic                     text_done
);

    import ghash_pkg::*;
    import gcm_msg_pkg::*;

    // Zero every byte whose keep bit is low
    function automatic block_t mask_block(input block_t data, input keep_t keep);
        block_t res;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            res[i*8 +: 8] = keep[i] ? data[i*8 +: 8] : 8'h00;
        end
        return res;
    endfunction

    phase_e      phase_q;
    bit_len_t    len_aad_q;
    bit_len_t    len_text_q;
    ghash_item_t item_q;
    logic        item_vld_q;
    logic        aad_done_q;
    logic        text_done_q;

    logic        start_ok;
    logic        in_phase;
    logic        accept;
    logic        seg_end;
    logic        load_len;

    // --------------------
    // Handshakes
    // --------------------
    assign start_ok = start && (phase_q == PH_IDLE);
    assign in_phase = (phase_q == PH_AAD) || (phase_q == PH_TEXT);
    assign in_ready = in_phase && !full;
    assign accept   = in_valid && in_ready;
    assign seg_end  = accept && in_beat.last;
    assign load_len = (phase_q == PH_LEN) && !full;

    // Output register drains on any non-full cycle, so it is free again
    // whenever a new beat or the lengths block may load
    assign push = item_vld_q && !full;
    assign item = item_q;

    // --------------------
    // Phase machine
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= PH_IDLE;
        end else if (start_ok) begin
            if (cfg.len_aad_bits != '0) begin
                phase_q <= PH_AAD;
            end else if (cfg.len_text_bits != '0) begin
                phase_q <= PH_TEXT;
            end else begin
                phase_q <= PH_LEN;
            end
        end else begin
            case (phase_q)
                PH_AAD: begin
                    if (seg_end) begin
                        phase_q <= (len_text_q == '0) ? PH_LEN : PH_TEXT;
                    end
                end
                PH_TEXT: begin
                    if (seg_end) begin
                        phase_q <= PH_LEN;
                    end
                end
                PH_LEN: begin
                    if (load_len) begin
                        phase_q <= PH_IDLE;
                    end
                end
                default: ;
            endcase
        end
    end

    // Status flags, an empty segment counts as done at start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aad_done_q  <= 1'b0;
            text_done_q <= 1'b0;
        end else if (start_ok) begin
            aad_done_q  <= (cfg.len_aad_bits == '0);
            text_done_q <= (cfg.len_text_bits == '0);
        end else if (seg_end) begin
            if (phase_q == PH_AAD) begin
                aad_done_q <= 1'b1;
            end else begin
                text_done_q <= 1'b1;
            end
        end
    end

    assign aad_done  = aad_done_q;
    assign text_done = text_done_q;

    // --------------------
    // Item register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            item_vld_q <= 1'b0;
        end else if (accept || load_len) begin
            item_vld_q <= 1'b1;
        end else if (push) begin
            item_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            len_aad_q  <= cfg.len_aad_bits;
            len_text_q <= cfg.len_text_bits;
        end
        if (accept) begin
            item_q.blk      <= mask_block(in_beat.data, in_beat.keep);
            item_q.is_final <= 1'b0;
        end else if (load_len) begin
            // AAD length in the upper half, text length in the lower half
            item_q.blk      <= {len_aad_q, len_text_q};
            item_q.is_final <= 1'b1;
        end
    end

endmodule

// File: src/gcm_msg_pkg.sv
package gcm_msg_pkg;

    // --------------------
    // Message setup
    // --------------------

    // Segment length in bits, as in the GCM lengths block
    typedef logic [63:0] bit_len_t;

    // Sampled with the start strobe
    typedef struct packed {
        bit_len_t          len_aad_bits;
        bit_len_t          len_text_bits;
        ghash_pkg::block_t h;
    } msg_cfg_t;

    // --------------------
    // Streams
    // --------------------

    // One input beat, AAD or text depending on phase
    typedef struct packed {
        ghash_pkg::block_t data;
        ghash_pkg::keep_t  keep;
        logic              last;
    } beat_t;

    // Sequencer phases, in absorb order
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_AAD,
        PH_TEXT,
        PH_LEN
    } phase_e;

    // Masked block on its way to the multiplier
    typedef struct packed {
        ghash_pkg::block_t blk;
        logic              is_final;  // Lengths block only
    } ghash_item_t;

endpackage

// File: src/ghash_pkg.sv
package ghash_pkg;

    // --------------------
    // Block geometry
    // --------------------
    localparam int BLOCK_BITS  = 128;
    localparam int BLOCK_BYTES = BLOCK_BITS / 8;

    // One GHASH block, used for H, data and Y alike
    typedef logic [BLOCK_BITS-1:0] block_t;

    // Byte-valid bits, bit i covers data[i*8 +: 8]
    typedef logic [BLOCK_BYTES-1:0] keep_t;

    // --------------------
    // Field arithmetic
    // --------------------

    // Reduction polynomial x^128 + x^7 + x^2 + x + 1 in GCM bit order,
    // 8'hE1 in the top byte and zero below
    localparam block_t GHASH_R = {8'hE1, {(BLOCK_BITS-8){1'b0}}};

endpackage
